/* Bender.yml */
package:
  name: sdram_tg

sources:
  - src/sdram_tg_pkg.sv
  - src/sdram_tg_if.sv
  - src/sdram_tg_ctrl.sv
  - src/sdram_addr_gen.sv
  - src/sdram_data_gen.sv
  - src/sdram_pnf_checker.sv
  - src/sdram_tg_top.sv
  - target: simulation
    files:
      - sim/sdram_mem_model.sv
      - sim/sdram_tg_tb.sv

/* sim/sdram_mem_model.sv */
// ----------------------------------------
// SDRAM local-port responder
// random ready, stored bursts, delayed reads
// and single-bit error injection
// ----------------------------------------

`timescale 1ns/1ps

module sdram_mem_model #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                write_req,
  input  logic                read_req,
  input  logic                burstbegin,
  input  sdram_tg_pkg::row_t  row,
  input  sdram_tg_pkg::col_t  col,
  input  sdram_tg_pkg::bank_t bank,
  input  sdram_tg_pkg::data_t wdata,
  input  logic                inject_req,
  input  logic                inject_lane,
  output logic                ready,
  output sdram_tg_pkg::data_t rdata,
  output logic                rdata_valid,
  output logic                injected,
  output int                  write_bursts,
  output int                  read_bursts
);

  import sdram_tg_pkg::*;

  // stored words, keyed by bank, row, column and beat
  data_t        mem [int unsigned];
  logic [23:0]  rd_key_q [$];
  longint       rd_due_q [$];
  logic [23:0]  wr_key;
  logic [23:0]  s_key;
  data_t        s_wdata;
  int unsigned  rkey;
  longint       cycle;
  int           wr_beat;
  int           rd_beat;
  int           armed_lane;
  logic         armed;
  logic         s_wr_acc;
  logic         s_rd_acc;
  logic         s_first;
  logic         s_arm;
  logic         s_reset;

  initial
  begin
    void'($urandom(SEED));
    ready        = 1'b0;
    rdata        = '0;
    rdata_valid  = 1'b0;
    injected     = 1'b0;
    write_bursts = 0;
    read_bursts  = 0;
    cycle        = 0;
    wr_beat      = 0;
    rd_beat      = 0;
    armed        = 1'b0;
    armed_lane   = 0;
    wr_key       = '0;
    forever
    begin
      @(posedge clk);
      // DUT outputs as they stand at the edge
      s_reset  = !reset_n;
      s_wr_acc = write_req & ready;
      s_rd_acc = read_req & ready;
      s_first  = burstbegin;
      s_key    = {bank, row, col};
      s_wdata  = wdata;
      s_arm    = inject_req;
      #1;
      cycle++;
      rdata_valid = 1'b0;
      injected    = 1'b0;
      if (s_reset)
      begin
        rd_key_q.delete();
        rd_due_q.delete();
        write_bursts = 0;
        read_bursts  = 0;
        wr_beat      = 0;
        rd_beat      = 0;
        armed        = 1'b0;
      end
      else
      begin
        if (s_arm)
        begin
          armed      = 1'b1;
          armed_lane = inject_lane;
        end
        // address is taken from the first beat of a burst
        if (s_wr_acc)
        begin
          if (s_first)
          begin
            wr_key  = s_key;
            wr_beat = 0;
            write_bursts++;
          end
          mem[{wr_key, wr_beat[0]}] = s_wdata;
          wr_beat++;
        end
        if (s_rd_acc)
        begin
          rd_key_q.push_back(s_key);
          rd_due_q.push_back(cycle + $urandom_range(6, 2));
          read_bursts++;
        end
        // in-order return, one beat per cycle
        if (rd_key_q.size() > 0 && rd_due_q[0] <= cycle)
        begin
          rkey        = {rd_key_q[0], rd_beat[0]};
          rdata       = mem.exists(rkey) ? mem[rkey] : '0;
          rdata_valid = 1'b1;
          if (armed)
          begin
            rdata[armed_lane*8] = !rdata[armed_lane*8];
            injected = 1'b1;
            armed    = 1'b0;
          end
          if (rd_beat == BURST_LEN - 1)
          begin
            rd_beat = 0;
            void'(rd_key_q.pop_front());
            void'(rd_due_q.pop_front());
          end
          else
            rd_beat++;
        end
      end
      // roughly three cycles in four ready
      ready = ($urandom_range(3, 0) != 0);
    end
  end

endmodule

/* sim/sdram_tg_tb.sv */
// ----------------------------------------
// SDRAM traffic generator testbench
// directed passes against the memory model
// ----------------------------------------

`timescale 1ns/1ps

module sdram_tg_tb;

  import sdram_tg_pkg::*;

  localparam logic [31:0] SEED = 32'h6c7a_37c6;
  localparam int RESET_CYCLES  = 16;
  localparam int PASS_TIMEOUT  = 5000;
  localparam int NUM_BURSTS    = (int'(MAX_COL) / int'(COL_STEP) + 1) *
                                 (int'(MAX_ROW) + 1) * (int'(MAX_BANK) + 1);

  logic  clk;
  logic  reset_n;
  logic  local_ready;
  data_t local_rdata;
  logic  local_rdata_valid;
  logic  local_write_req;
  logic  local_read_req;
  logic  local_burstbegin;
  size_t local_size;
  row_t  local_row_addr;
  col_t  local_col_addr;
  bank_t local_bank_addr;
  data_t local_wdata;
  pnf_t  pnf_per_byte;
  logic  pnf_persist;
  logic  test_complete;
  logic  inject_req;
  logic  inject_lane;
  logic  injected;
  int    write_bursts;
  int    read_bursts;

  int    errors;
  int    tests_passed;
  int    tests_failed;
  bit    hung;
  bit    inject_seen;
  int    obs_writes;
  int    obs_reads;
  data_t first_wdata;
  data_t first_rdata;

  sdram_tg_top sdram_tg_top_i (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata       (local_rdata),
    .local_rdata_valid (local_rdata_valid),
    .local_write_req   (local_write_req),
    .local_read_req    (local_read_req),
    .local_burstbegin  (local_burstbegin),
    .local_size        (local_size),
    .local_row_addr    (local_row_addr),
    .local_col_addr    (local_col_addr),
    .local_bank_addr   (local_bank_addr),
    .local_wdata       (local_wdata),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist),
    .test_complete     (test_complete)
  );

  sdram_mem_model #(.SEED(SEED)) mem_model_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .write_req    (local_write_req),
    .read_req     (local_read_req),
    .burstbegin   (local_burstbegin),
    .row          (local_row_addr),
    .col          (local_col_addr),
    .bank         (local_bank_addr),
    .wdata        (local_wdata),
    .inject_req   (inject_req),
    .inject_lane  (inject_lane),
    .ready        (local_ready),
    .rdata        (local_rdata),
    .rdata_valid  (local_rdata_valid),
    .injected     (injected),
    .write_bursts (write_bursts),
    .read_bursts  (read_bursts)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------
  // reporting helpers
  // ----------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("ERROR at %0t: %s got %0h expected %0h", $time, name, got, exp);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("FAILURE at %0t: %s", $time, msg);
  endtask

  task automatic log_test_result(input string name, input int errs_before);
    if (errors == errs_before)
    begin
      tests_passed++;
      $display("test %s: pass", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, errors - errs_before);
    end
  endtask

  // column first, then row, then bank
  task automatic step_address(inout bank_t bank, inout row_t row, inout col_t col);
    if (col + COL_STEP <= MAX_COL)
      col = col + COL_STEP;
    else
    begin
      col = '0;
      if (row < MAX_ROW)
        row = row + 1'b1;
      else
      begin
        row  = '0;
        bank = bank + 1'b1;
      end
    end
  endtask

  // both byte lanes one step on, taps 8,6,5,4
  function automatic data_t next_lfsr_word(input data_t word);
    data_t nxt;
    for (int i = 0; i < NUM_LANES; i++)
      nxt[i*8 +: 8] = {word[i*8 +: 7], ^(word[i*8 +: 8] & 8'hB8)};
    return nxt;
  endfunction

  // ----------------------------------------
  // one pass, watched cycle by cycle
  // ----------------------------------------
  task automatic run_pass(input bit check_order);
    int    cycles;
    int    beat;
    int    since_inject;
    bit    done;
    bit    got_first_rd;
    bank_t wr_bank;
    row_t  wr_row;
    col_t  wr_col;
    bank_t rd_bank;
    row_t  rd_row;
    col_t  rd_col;
    data_t exp_wdata;
    cycles       = 0;
    beat         = 0;
    since_inject = -1;
    done         = 1'b0;
    got_first_rd = 1'b0;
    wr_bank      = '0;
    wr_row       = '0;
    wr_col       = '0;
    rd_bank      = '0;
    rd_row       = '0;
    rd_col       = '0;
    exp_wdata    = {LANE1_SEED, LANE0_SEED};
    obs_writes   = 0;
    obs_reads    = 0;
    inject_seen  = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      cycles++;
      if (since_inject >= 0)
        since_inject++;
      if (since_inject == 3 && pnf_per_byte !== 2'b01)
        report_mismatch("pnf_per_byte", pnf_per_byte, 2'b01);
      if (since_inject >= 4 && pnf_persist !== 1'b0)
        report_mismatch("pnf_persist", pnf_persist, 1'b0);
      if (injected)
      begin
        since_inject = 0;
        inject_seen  = 1'b1;
      end
      if (check_order && local_write_req && local_ready)
      begin
        if (local_size !== BURST_LEN)
          report_mismatch("local_size", local_size, BURST_LEN);
        if (local_wdata !== exp_wdata)
          report_mismatch("local_wdata", local_wdata, exp_wdata);
        exp_wdata = next_lfsr_word(exp_wdata);
        if (beat == 0)
        begin
          if (local_burstbegin !== 1'b1)
            report_mismatch("local_burstbegin", local_burstbegin, 1'b1);
          if ({local_bank_addr, local_row_addr, local_col_addr} !== {wr_bank, wr_row, wr_col})
            report_mismatch("write address", {local_bank_addr, local_row_addr, local_col_addr},
                            {wr_bank, wr_row, wr_col});
          if (obs_writes == 0)
            first_wdata = local_wdata;
          obs_writes++;
          step_address(wr_bank, wr_row, wr_col);
        end
        else if (local_burstbegin !== 1'b0)
          report_mismatch("local_burstbegin", local_burstbegin, 1'b0);
        beat = (beat == BURST_LEN - 1) ? 0 : beat + 1;
      end
      if (check_order && local_read_req && local_ready)
      begin
        if (local_size !== BURST_LEN)
          report_mismatch("local_size", local_size, BURST_LEN);
        if (local_burstbegin !== 1'b1)
          report_mismatch("local_burstbegin", local_burstbegin, 1'b1);
        if ({local_bank_addr, local_row_addr, local_col_addr} !== {rd_bank, rd_row, rd_col})
          report_mismatch("read address", {local_bank_addr, local_row_addr, local_col_addr},
                          {rd_bank, rd_row, rd_col});
        obs_reads++;
        step_address(rd_bank, rd_row, rd_col);
      end
      if (local_rdata_valid && !got_first_rd)
      begin
        first_rdata  = local_rdata;
        got_first_rd = 1'b1;
      end
      if (test_complete)
        done = 1'b1;
      else if (cycles >= PASS_TIMEOUT)
      begin
        report_problem("test_complete never came, the pass timed out");
        hung = 1'b1;
        done = 1'b1;
      end
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic check_reset_values();
    int errs_before;
    errs_before = errors;
    for (int i = 0; i < RESET_CYCLES; i++)
    begin
      @(posedge clk);
      #1;
      if (local_write_req !== 1'b0)
        report_mismatch("local_write_req", local_write_req, 1'b0);
      if (local_read_req !== 1'b0)
        report_mismatch("local_read_req", local_read_req, 1'b0);
      if (local_burstbegin !== 1'b0)
        report_mismatch("local_burstbegin", local_burstbegin, 1'b0);
      if (test_complete !== 1'b0)
        report_mismatch("test_complete", test_complete, 1'b0);
      if (pnf_per_byte !== '1)
        report_mismatch("pnf_per_byte", pnf_per_byte, 2'b11);
      if (pnf_persist !== 1'b0)
        report_mismatch("pnf_persist", pnf_persist, 1'b0);
    end
    reset_n = 1'b1;
    log_test_result("reset values", errs_before);
  endtask

  task automatic check_clean_pass();
    int errs_before;
    int writes_before;
    int reads_before;
    errs_before   = errors;
    writes_before = write_bursts;
    reads_before  = read_bursts;
    run_pass(1'b1);
    if (!hung)
    begin
      if (obs_writes != NUM_BURSTS)
        report_mismatch("observed write bursts", obs_writes, NUM_BURSTS);
      if (obs_reads != NUM_BURSTS)
        report_mismatch("observed read requests", obs_reads, NUM_BURSTS);
      if (write_bursts - writes_before != NUM_BURSTS)
        report_mismatch("model write bursts", write_bursts - writes_before, NUM_BURSTS);
      if (read_bursts - reads_before != NUM_BURSTS)
        report_mismatch("model read requests", read_bursts - reads_before, NUM_BURSTS);
    end
    log_test_result("full pass with back-pressure", errs_before);
  endtask

  task automatic check_readback();
    int errs_before;
    errs_before = errors;
    // let the last beat reach both flags
    for (int i = 0; i < 4; i++)
      @(posedge clk);
    if (pnf_per_byte !== '1)
      report_mismatch("pnf_per_byte", pnf_per_byte, 2'b11);
    if (pnf_persist !== 1'b1)
      report_mismatch("pnf_persist", pnf_persist, 1'b1);
    if (first_wdata !== {LANE1_SEED, LANE0_SEED})
      report_mismatch("first local_wdata", first_wdata, {LANE1_SEED, LANE0_SEED});
    if (first_rdata !== first_wdata)
      report_mismatch("first local_rdata", first_rdata, first_wdata);
    log_test_result("clean read back", errs_before);
  endtask

  task automatic check_injected_error();
    int errs_before;
    errs_before = errors;
    @(posedge clk);
    #1;
    inject_lane = 1'b1;
    inject_req  = 1'b1;
    @(posedge clk);
    #1;
    inject_req = 1'b0;
    run_pass(1'b0);
    if (!hung)
    begin
      if (!inject_seen)
        report_problem("no corrupted read beat came back in the second pass");
      for (int i = 0; i < 4; i++)
        @(posedge clk);
      if (pnf_persist !== 1'b0)
        report_mismatch("pnf_persist", pnf_persist, 1'b0);
    end
    log_test_result("lane 1 bit error", errs_before);
  endtask

  initial
  begin
    reset_n      = 1'b0;
    inject_req   = 1'b0;
    inject_lane  = 1'b0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    hung         = 1'b0;
    check_reset_values();
    if (!hung)
      check_clean_pass();
    if (!hung)
      check_readback();
    if (!hung)
      check_injected_error();
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (hung || errors != 0)
      $display("Simulation FAILED");
    else
      $display("Simulation PASSED");
    $finish;
  end

endmodule

/* src/sdram_addr_gen.sv */
// --------------------------------------
// SDRAM traffic generator address counter
// column, then row, then bank per burst
// --------------------------------------

`timescale 1ns/1ps

module sdram_addr_gen (
  input  logic               clk,
  input  logic               reset_n,
  sdram_tg_if.addr           tg,
  output sdram_tg_pkg::row_t  row,
  output sdram_tg_pkg::col_t  col,
  output sdram_tg_pkg::bank_t bank
);

  import sdram_tg_pkg::*;

  assign tg.addr_last = (col == MAX_COL) && (row == MAX_ROW) && (bank == MAX_BANK);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      row  <= '0;
      col  <= '0;
      bank <= '0;
    end
    else if (tg.addr_restart)
    begin
      row  <= '0;
      col  <= '0;
      bank <= '0;
    end
    else if (tg.addr_advance)
    begin
      // nested wrap at each field limit
      if (col >= MAX_COL)
      begin
        col <= '0;
        if (row == MAX_ROW)
        begin
          row  <= '0;
          bank <= (bank == MAX_BANK) ? '0 : bank + 1'b1;
        end
        else
          row <= row + 1'b1;
      end
      else
        col <= col + COL_STEP;
    end
  end

endmodule

/* src/sdram_data_gen.sv */
// --------------------------------------
// SDRAM traffic generator data source
// one 8-bit lfsr per lane, seed save/reload
// --------------------------------------

`timescale 1ns/1ps

module sdram_data_gen (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                step,
  sdram_tg_if.data            tg,
  output sdram_tg_pkg::data_t data
);

  import sdram_tg_pkg::*;

  byte_t lane [NUM_LANES];
  data_t seed_word;

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic byte_t lfsr_next(input byte_t cur);
    lfsr_next = {cur[6:0], cur[7] ^ cur[5] ^ cur[4] ^ cur[3]};
  endfunction

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
      data[i*8 +: 8] = lane[i];
  end

  // ----------------------------------------
  // lane registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      lane[0] <= LANE0_SEED;
      lane[1] <= LANE1_SEED;
    end
    else
    begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
        // reload wins over a step in the same cycle
        if (tg.seed_load)
          lane[i] <= seed_word[i*8 +: 8];
        else if (step)
          lane[i] <= lfsr_next(lane[i]);
      end
    end
  end

  // first word of the pass, replayed for the read back
  always_ff @(posedge clk)
  begin
    if (tg.seed_capture)
      seed_word <= data;
  end

endmodule

/* src/sdram_pnf_checker.sv */
// --------------------------------------
// SDRAM traffic generator read checker
// per-lane compare and sticky pass flag
// --------------------------------------

`timescale 1ns/1ps

module sdram_pnf_checker (
  input  logic                clk,
  input  logic                reset_n,
  input  sdram_tg_pkg::data_t expected,
  input  sdram_tg_pkg::data_t rdata,
  input  logic                rdata_valid,
  output sdram_tg_pkg::pnf_t  pnf_per_byte,
  output logic                pnf_persist
);

  import sdram_tg_pkg::*;

  pnf_t compare;
  pnf_t compare_reg;
  pnf_t compare_valid;
  logic valid_d1;
  logic seen_valid;
  logic seen_d1;
  logic seen_d2;
  logic persist_pre;

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
      compare[i] = (expected[i*8 +: 8] == rdata[i*8 +: 8]);
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      compare_reg   <= '1;
      compare_valid <= '1;
      pnf_per_byte  <= '1;
      valid_d1      <= 1'b0;
      seen_valid    <= 1'b0;
      seen_d1       <= 1'b0;
      seen_d2       <= 1'b0;
      persist_pre   <= 1'b0;
      pnf_persist   <= 1'b0;
    end
    else
    begin
      compare_reg <= compare;
      valid_d1    <= rdata_valid;
      if (valid_d1)
        compare_valid <= compare_reg;
      // output stage
      pnf_per_byte <= compare_valid;
      // first read beat seen, then aged to line up with compare_valid
      if (rdata_valid)
        seen_valid <= 1'b1;
      seen_d1 <= seen_valid;
      seen_d2 <= seen_d1;
      // once low, stays low until reset
      persist_pre <= (&compare_valid) & seen_d1 & (seen_d2 ? persist_pre : 1'b1);
      pnf_persist <= persist_pre;
    end
  end

endmodule

/* src/sdram_tg_ctrl.sv */
// --------------------------------------
// SDRAM traffic generator pass FSM
// write bursts, read back, then signal done
// --------------------------------------

`timescale 1ns/1ps

module sdram_tg_ctrl (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     local_ready,
  input  logic     local_rdata_valid,
  output logic     write_req,
  output logic     read_req,
  output logic     burst_begin,
  output logic     test_complete,
  sdram_tg_if.ctrl tg
);

  import sdram_tg_pkg::*;

  ctrl_state_t state;
  logic        first_burst;
  logic [7:0]  reads_pending;
  logic        write_accept;
  logic        read_accept;

  assign write_accept = write_req & local_ready;
  assign read_accept  = read_req & local_ready;

  // no advance on the final burst, the address is restarted instead
  assign tg.addr_advance = ((state == WRITE_FIRST) && write_accept && !tg.addr_last) ||
                           ((state == READ) && read_accept && !tg.addr_last);
  assign tg.addr_restart = ((state == WRITE_LAST) && write_accept) || (state == DONE);
  assign tg.seed_capture = first_burst && (state == WRITE_FIRST) && write_accept;
  assign tg.seed_load    = (state == WRITE_LAST) && write_accept;

  // ----------------------------------------
  // outstanding read beats
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      reads_pending <= '0;
    else
    begin
      case ({read_accept, local_rdata_valid})
        2'b10:   reads_pending <= reads_pending + BURST_LEN;
        2'b11:   reads_pending <= reads_pending + BURST_LEN - 1'b1;
        2'b01:   reads_pending <= reads_pending - 1'b1;
        default: reads_pending <= reads_pending;
      endcase
    end
  end

  // ----------------------------------------
  // pass sequencing
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= START;
      write_req     <= 1'b0;
      read_req      <= 1'b0;
      burst_begin   <= 1'b0;
      test_complete <= 1'b0;
      first_burst   <= 1'b0;
    end
    else
    begin
      case (state)
        START:
        begin
          write_req   <= 1'b1;
          burst_begin <= 1'b1;
          first_burst <= 1'b1;
          state       <= WRITE_FIRST;
        end
        WRITE_FIRST:
          if (write_accept)
          begin
            burst_begin <= 1'b0;
            first_burst <= 1'b0;
            state       <= tg.addr_last ? WRITE_LAST : WRITE_REST;
          end
        WRITE_REST:
          if (write_accept)
          begin
            burst_begin <= 1'b1;
            state       <= WRITE_FIRST;
          end
        // second beat of the final write burst
        WRITE_LAST:
          if (write_accept)
          begin
            write_req   <= 1'b0;
            read_req    <= 1'b1;
            burst_begin <= 1'b1;
            state       <= READ;
          end
        READ:
          if (read_accept && tg.addr_last)
          begin
            read_req    <= 1'b0;
            burst_begin <= 1'b0;
            state       <= READ_DRAIN;
          end
        READ_DRAIN:
          if (reads_pending == '0)
          begin
            test_complete <= 1'b1;
            state         <= DONE;
          end
        DONE:
        begin
          test_complete <= 1'b0;
          state         <= START;
        end
        default: state <= START;
      endcase
    end
  end

endmodule

/* src/sdram_tg_if.sv */
// --------------------------------------
// SDRAM traffic generator sideband
// address and seed control between blocks
// --------------------------------------

`timescale 1ns/1ps

interface sdram_tg_if;

  // address counter control
  logic addr_restart;
  logic addr_advance;
  logic addr_last;

  // lfsr seed control
  logic seed_capture;
  logic seed_load;

  modport ctrl (
    output addr_restart,
    output addr_advance,
    output seed_capture,
    output seed_load,
    input  addr_last
  );

  modport addr (
    input  addr_restart,
    input  addr_advance,
    output addr_last
  );

  modport data (
    input seed_capture,
    input seed_load
  );

endinterface

/* src/sdram_tg_pkg.sv */
// --------------------------------------
// SDRAM traffic generator package
// widths, address limits, burst length and
// controller states shared by the design
// --------------------------------------

package sdram_tg_pkg;

  // local port data and byte lanes
  typedef logic [15:0] data_t;
  typedef logic [7:0]  byte_t;
  localparam int unsigned NUM_LANES = 2;
  typedef logic [NUM_LANES-1:0] pnf_t;

  // local address fields
  typedef logic [11:0] row_t;
  typedef logic [9:0]  col_t;
  typedef logic [1:0]  bank_t;
  typedef logic [2:0]  size_t;

  // burst shape
  localparam size_t BURST_LEN = 3'd2;
  localparam col_t  COL_STEP  = 10'd4;

  // ----------------------------------------
  // test region limits
  // ----------------------------------------
  localparam col_t  MAX_COL  = 10'd16;
  localparam row_t  MAX_ROW  = 12'd3;
  localparam bank_t MAX_BANK = 2'd3;

  // lfsr reset values per lane
  localparam byte_t LANE0_SEED = 8'd1;
  localparam byte_t LANE1_SEED = 8'd11;

  typedef enum logic [2:0] {
    START,
    WRITE_FIRST,
    WRITE_REST,
    WRITE_LAST,
    READ,
    READ_DRAIN,
    DONE
  } ctrl_state_t;

endpackage

/* src/sdram_tg_top.sv */
// --------------------------------------
// SDRAM traffic generator top level
// drives the controller local port
// --------------------------------------

`timescale 1ns/1ps

module sdram_tg_top (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                local_ready,
  input  sdram_tg_pkg::data_t local_rdata,
  input  logic                local_rdata_valid,
  output logic                local_write_req,
  output logic                local_read_req,
  output logic                local_burstbegin,
  output sdram_tg_pkg::size_t local_size,
  output sdram_tg_pkg::row_t  local_row_addr,
  output sdram_tg_pkg::col_t  local_col_addr,
  output sdram_tg_pkg::bank_t local_bank_addr,
  output sdram_tg_pkg::data_t local_wdata,
  output sdram_tg_pkg::pnf_t  pnf_per_byte,
  output logic                pnf_persist,
  output logic                test_complete
);

  import sdram_tg_pkg::*;

  data_t gen_data;
  logic  data_step;

  sdram_tg_if tg_if ();

  // one lfsr step per accepted write beat or returned read beat
  assign data_step   = (local_write_req & local_ready) | local_rdata_valid;
  assign local_wdata = gen_data;
  assign local_size  = BURST_LEN;

  sdram_tg_ctrl ctrl_i (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .write_req         (local_write_req),
    .read_req          (local_read_req),
    .burst_begin       (local_burstbegin),
    .test_complete     (test_complete),
    .tg                (tg_if.ctrl)
  );

  sdram_addr_gen addr_gen_i (
    .clk     (clk),
    .reset_n (reset_n),
    .tg      (tg_if.addr),
    .row     (local_row_addr),
    .col     (local_col_addr),
    .bank    (local_bank_addr)
  );

  sdram_data_gen data_gen_i (
    .clk     (clk),
    .reset_n (reset_n),
    .step    (data_step),
    .tg      (tg_if.data),
    .data    (gen_data)
  );

  sdram_pnf_checker pnf_checker_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .expected     (gen_data),
    .rdata        (local_rdata),
    .rdata_valid  (local_rdata_valid),
    .pnf_per_byte (pnf_per_byte),
    .pnf_persist  (pnf_persist)
  );

endmodule

/* vlog.f */
src/sdram_tg_pkg.sv
src/sdram_tg_if.sv
src/sdram_tg_ctrl.sv
src/sdram_addr_gen.sv
src/sdram_data_gen.sv
src/sdram_pnf_checker.sv
src/sdram_tg_top.sv
sim/sdram_mem_model.sv
sim/sdram_tg_tb.sv
